/* source/rv32i_pkg.sv */
package rv32i_pkg;

	// base opcodes handled by the load/store unit
	localparam logic [6:0] op_load  = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;

	// width field, shared by loads and stores
	localparam logic [2:0] f3_b  = 3'b000;
	localparam logic [2:0] f3_h  = 3'b001;
	localparam logic [2:0] f3_w  = 3'b010;
	localparam logic [2:0] f3_bu = 3'b100;
	localparam logic [2:0] f3_hu = 3'b101;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} instr_i_t;

	// immediate split around rs2/rs1/funct3
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} instr_s_t;

	// same word, read per opcode
	typedef union packed {
		instr_i_t itype;
		instr_s_t stype;
	} instr_t;

endpackage

/* source/lsq_pkg.sv */
package lsq_pkg;

	// reorder-buffer tag
	localparam int tag_width = 4;

	typedef logic [tag_width-1:0] tag_t;

	// queue geometry, depth is a power of two so pointers wrap on their own
	localparam int lsq_depth = 8;
	localparam int ptr_width = 3;

	typedef logic [ptr_width-1:0] ptr_t;

endpackage

/* source/lsq_decode.sv */
module lsq_decode (
	input  logic               issue_valid,
	input  rv32i_pkg::instr_t  issue_instr,
	input  lsq_pkg::tag_t      issue_tag,
	input  logic               base_pending,
	input  logic [31:0]        base_value,
	input  logic               data_pending,
	input  logic [31:0]        data_value,
	output logic               enq,
	output logic               is_load,
	output logic [2:0]         funct3,
	output logic [31:0]        imm,
	output logic               addr_pending,
	output logic [31:0]        addr_or_tag,
	output logic               data_pending_out,
	output logic [31:0]        data_or_tag,
	output lsq_pkg::tag_t      tag
);

	logic        is_store;
	logic [31:0] imm_i;
	logic [31:0] imm_s;

	assign is_load  = issue_instr.itype.opcode == rv32i_pkg::op_load;
	assign is_store = issue_instr.stype.opcode == rv32i_pkg::op_store;

	// anything else is dropped here
	assign enq = issue_valid && (is_load || is_store);

	assign imm_i = {{20{issue_instr.itype.imm[11]}}, issue_instr.itype.imm};
	assign imm_s = {{20{issue_instr.stype.imm_hi[6]}}, issue_instr.stype.imm_hi,
			issue_instr.stype.imm_lo};
	assign imm   = is_store ? imm_s : imm_i;

	// funct3 sits in the same bits for both formats
	assign funct3 = issue_instr.itype.funct3;

	// pending base keeps its tag, the add happens on capture
	assign addr_pending = base_pending;
	assign addr_or_tag  = base_pending ? base_value : base_value + imm;

	// loads carry no store data
	assign data_pending_out = is_store && data_pending;
	assign data_or_tag      = data_value;

	assign tag = issue_tag;

endmodule

/* source/lsq_queue.sv */
module lsq_queue (
	input  logic           clk,
	input  logic           rst,
	input  logic           enq,
	input  logic           is_load,
	input  logic [2:0]     funct3,
	input  logic [31:0]    imm,
	input  logic           addr_pending,
	input  logic [31:0]    addr_or_tag,
	input  logic           data_pending,
	input  logic [31:0]    data_or_tag,
	input  lsq_pkg::tag_t  tag,
	input  logic           cdb_valid,
	input  lsq_pkg::tag_t  cdb_tag,
	input  logic [31:0]    cdb_data,
	input  logic           deq,
	output logic           full,
	output logic           head_valid,
	output logic           head_is_load,
	output logic [2:0]     head_funct3,
	output logic [31:0]    head_addr,
	output logic [31:0]    head_data,
	output lsq_pkg::tag_t  head_tag
);

	logic                  e_is_load   [lsq_pkg::lsq_depth];
	logic [2:0]            e_funct3    [lsq_pkg::lsq_depth];
	logic [31:0]           e_imm       [lsq_pkg::lsq_depth];
	logic                  e_addr_pend [lsq_pkg::lsq_depth];
	logic [31:0]           e_addr      [lsq_pkg::lsq_depth];
	logic                  e_data_pend [lsq_pkg::lsq_depth];
	logic [31:0]           e_data      [lsq_pkg::lsq_depth];
	lsq_pkg::tag_t         e_tag       [lsq_pkg::lsq_depth];

	lsq_pkg::ptr_t               head;
	lsq_pkg::ptr_t               tail;
	logic [lsq_pkg::ptr_width:0] count;

	logic in_addr_hit;
	logic in_data_hit;

	assign full = count == lsq_pkg::lsq_depth;

	assign head_valid   = (count != 0) && !e_addr_pend[head] && !e_data_pend[head];
	assign head_is_load = e_is_load[head];
	assign head_funct3  = e_funct3[head];
	assign head_addr    = e_addr[head];
	assign head_data    = e_data[head];
	assign head_tag     = e_tag[head];

	// broadcast seen in the same cycle as the write
	assign in_addr_hit = cdb_valid && addr_pending
			&& addr_or_tag[lsq_pkg::tag_width-1:0] == cdb_tag;
	assign in_data_hit = cdb_valid && data_pending
			&& data_or_tag[lsq_pkg::tag_width-1:0] == cdb_tag;

	always_ff @(posedge clk) begin
		for (int i = 0; i < lsq_pkg::lsq_depth; i++) begin
			if (cdb_valid && e_addr_pend[i]
					&& e_addr[i][lsq_pkg::tag_width-1:0] == cdb_tag) begin
				e_addr[i]      <= cdb_data + e_imm[i];
				e_addr_pend[i] <= 1'b0;
			end
			if (cdb_valid && e_data_pend[i]
					&& e_data[i][lsq_pkg::tag_width-1:0] == cdb_tag) begin
				e_data[i]      <= cdb_data;
				e_data_pend[i] <= 1'b0;
			end
		end
		if (enq) begin
			e_is_load[tail]   <= is_load;
			e_funct3[tail]    <= funct3;
			e_imm[tail]       <= imm;
			e_addr_pend[tail] <= addr_pending && !in_addr_hit;
			e_addr[tail]      <= in_addr_hit ? cdb_data + imm : addr_or_tag;
			e_data_pend[tail] <= data_pending && !in_data_hit;
			e_data[tail]      <= in_data_hit ? cdb_data : data_or_tag;
			e_tag[tail]       <= tag;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (enq)
				tail <= tail + 1'b1;
			if (deq)
				head <= head + 1'b1;
			case ({enq, deq})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// issuer has to honour the stall
	assert property (@(posedge clk) disable iff (rst) !(enq && full));

	assert property (@(posedge clk) disable iff (rst) deq |-> head_valid);

	assert property (@(posedge clk) disable iff (rst) count <= lsq_pkg::lsq_depth);

endmodule

/* source/lsq_mem_access.sv */
module lsq_mem_access (
	input  logic           clk,
	input  logic           rst,
	input  logic           head_valid,
	input  logic           head_is_load,
	input  logic [2:0]     head_funct3,
	input  logic [31:0]    head_addr,
	input  logic [31:0]    head_data,
	input  lsq_pkg::tag_t  head_tag,
	input  logic           mem_resp,
	output logic           deq,
	output logic           mem_read,
	output logic           mem_write,
	output logic [31:0]    mem_address,
	output logic [3:0]     mem_byte_enable,
	output logic [31:0]    mem_wdata,
	output logic           done_is_load,
	output logic [2:0]     done_funct3,
	output logic [1:0]     done_offset,
	output lsq_pkg::tag_t  done_tag,
	output logic [31:0]    done_data
);

	logic        busy;
	logic [1:0]  offset;
	logic [3:0]  byte_enable;
	logic [31:0] wdata;

	assign busy   = mem_read || mem_write;
	assign offset = head_addr[1:0];

	// head leaves the queue in the response cycle
	assign deq = busy && mem_resp;

	always_comb begin
		case (head_funct3)
			rv32i_pkg::f3_b, rv32i_pkg::f3_bu: begin
				byte_enable = 4'b0001 << offset;
				wdata       = {4{head_data[7:0]}};
			end
			rv32i_pkg::f3_h, rv32i_pkg::f3_hu: begin
				byte_enable = 4'b0011 << offset;
				wdata       = {2{head_data[15:0]}};
			end
			rv32i_pkg::f3_w: begin
				byte_enable = 4'b1111;
				wdata       = head_data;
			end
			default: begin
				byte_enable = 4'b1111;
				wdata       = head_data;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_read  <= 1'b0;
			mem_write <= 1'b0;
		end else if (busy && mem_resp) begin
			mem_read  <= 1'b0;
			mem_write <= 1'b0;
		end else if (!busy && head_valid) begin
			mem_read  <= head_is_load;
			mem_write <= !head_is_load;
		end
	end

	// outstanding access, held until the response
	always_ff @(posedge clk) begin
		if (!busy && head_valid) begin
			mem_address     <= {head_addr[31:2], 2'b00};
			mem_byte_enable <= byte_enable;
			mem_wdata       <= wdata;
			done_is_load    <= head_is_load;
			done_funct3     <= head_funct3;
			done_offset     <= offset;
			done_tag        <= head_tag;
			done_data       <= head_data;
		end
	end

	assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write));

	assert property (@(posedge clk) disable iff (rst)
			busy && !mem_resp |=> $stable(mem_address));

endmodule

/* source/lsq_result.sv */
module lsq_result (
	input  logic           clk,
	input  logic           rst,
	input  logic           mem_resp,
	input  logic [31:0]    mem_rdata,
	input  logic           done_is_load,
	input  logic [2:0]     done_funct3,
	input  logic [1:0]     done_offset,
	input  lsq_pkg::tag_t  done_tag,
	input  logic [31:0]    done_data,
	output logic           result_valid,
	output lsq_pkg::tag_t  result_tag,
	output logic [31:0]    result_data
);

	logic [31:0] shifted;
	logic [31:0] load_value;

	// bring the addressed lane down to bit 0
	assign shifted = mem_rdata >> {done_offset, 3'b000};

	always_comb begin
		case (done_funct3)
			rv32i_pkg::f3_b:  load_value = {{24{shifted[7]}}, shifted[7:0]};
			rv32i_pkg::f3_bu: load_value = {24'b0, shifted[7:0]};
			rv32i_pkg::f3_h:  load_value = {{16{shifted[15]}}, shifted[15:0]};
			rv32i_pkg::f3_hu: load_value = {16'b0, shifted[15:0]};
			rv32i_pkg::f3_w:  load_value = shifted;
			default:          load_value = shifted;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			result_valid <= 1'b0;
		else
			result_valid <= mem_resp;
	end

	// stores report their own data
	always_ff @(posedge clk) begin
		if (mem_resp) begin
			result_tag  <= done_tag;
			result_data <= done_is_load ? load_value : done_data;
		end
	end

endmodule

/* source/load_store_unit.sv */
module load_store_unit (
	input  logic               clk,
	input  logic               rst,
	input  logic               issue_valid,
	input  rv32i_pkg::instr_t  issue_instr,
	input  lsq_pkg::tag_t      issue_tag,
	input  logic               base_pending,
	input  logic [31:0]        base_value,
	input  logic               data_pending,
	input  logic [31:0]        data_value,
	input  logic               cdb_valid,
	input  lsq_pkg::tag_t      cdb_tag,
	input  logic [31:0]        cdb_data,
	input  logic               mem_resp,
	input  logic [31:0]        mem_rdata,
	output logic               lsq_stall,
	output logic               mem_read,
	output logic               mem_write,
	output logic [31:0]        mem_address,
	output logic [3:0]         mem_byte_enable,
	output logic [31:0]        mem_wdata,
	output logic               result_valid,
	output lsq_pkg::tag_t      result_tag,
	output logic [31:0]        result_data
);

	logic          enq;
	logic          is_load;
	logic [2:0]    funct3;
	logic [31:0]   imm;
	logic          addr_pending;
	logic [31:0]   addr_or_tag;
	logic          entry_data_pending;
	logic [31:0]   data_or_tag;
	lsq_pkg::tag_t entry_tag;

	logic          deq;
	logic          head_valid;
	logic          head_is_load;
	logic [2:0]    head_funct3;
	logic [31:0]   head_addr;
	logic [31:0]   head_data;
	lsq_pkg::tag_t head_tag;

	logic          done_is_load;
	logic [2:0]    done_funct3;
	logic [1:0]    done_offset;
	lsq_pkg::tag_t done_tag;
	logic [31:0]   done_data;

	lsq_decode u_decode (
		.issue_valid      (issue_valid),
		.issue_instr      (issue_instr),
		.issue_tag        (issue_tag),
		.base_pending     (base_pending),
		.base_value       (base_value),
		.data_pending     (data_pending),
		.data_value       (data_value),
		.enq              (enq),
		.is_load          (is_load),
		.funct3           (funct3),
		.imm              (imm),
		.addr_pending     (addr_pending),
		.addr_or_tag      (addr_or_tag),
		.data_pending_out (entry_data_pending),
		.data_or_tag      (data_or_tag),
		.tag              (entry_tag)
	);

	// stall is the queue full level
	lsq_queue u_queue (
		.clk          (clk),
		.rst          (rst),
		.enq          (enq),
		.is_load      (is_load),
		.funct3       (funct3),
		.imm          (imm),
		.addr_pending (addr_pending),
		.addr_or_tag  (addr_or_tag),
		.data_pending (entry_data_pending),
		.data_or_tag  (data_or_tag),
		.tag          (entry_tag),
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.cdb_data     (cdb_data),
		.deq          (deq),
		.full         (lsq_stall),
		.head_valid   (head_valid),
		.head_is_load (head_is_load),
		.head_funct3  (head_funct3),
		.head_addr    (head_addr),
		.head_data    (head_data),
		.head_tag     (head_tag)
	);

	lsq_mem_access u_mem_access (
		.clk             (clk),
		.rst             (rst),
		.head_valid      (head_valid),
		.head_is_load    (head_is_load),
		.head_funct3     (head_funct3),
		.head_addr       (head_addr),
		.head_data       (head_data),
		.head_tag        (head_tag),
		.mem_resp        (mem_resp),
		.deq             (deq),
		.mem_read        (mem_read),
		.mem_write       (mem_write),
		.mem_address     (mem_address),
		.mem_byte_enable (mem_byte_enable),
		.mem_wdata       (mem_wdata),
		.done_is_load    (done_is_load),
		.done_funct3     (done_funct3),
		.done_offset     (done_offset),
		.done_tag        (done_tag),
		.done_data       (done_data)
	);

	lsq_result u_result (
		.clk          (clk),
		.rst          (rst),
		.mem_resp     (mem_resp),
		.mem_rdata    (mem_rdata),
		.done_is_load (done_is_load),
		.done_funct3  (done_funct3),
		.done_offset  (done_offset),
		.done_tag     (done_tag),
		.done_data    (done_data),
		.result_valid (result_valid),
		.result_tag   (result_tag),
		.result_data  (result_data)
	);

endmodule

/* tests/load_store_unit_tb.sv */
module load_store_unit_tb;

	localparam int timeout_cycles = 400;
	localparam logic [31:0] seed = 32'd74;

	typedef struct packed {
		logic          is_load;
		logic [2:0]    f3;
		logic [11:0]   imm;
		lsq_pkg::tag_t tag;
		logic [31:0]   base;
		logic [31:0]   data;
		logic          base_pend;
		logic          data_pend;
		logic          bcast;
		logic [3:0]    bcast_wait;
		lsq_pkg::tag_t bcast_tag;
		logic [31:0]   bcast_value;
		logic          drain;
		logic          stall;
	} row_t;

	logic               clk;
	logic               rst;
	logic               issue_valid;
	rv32i_pkg::instr_t  issue_instr;
	lsq_pkg::tag_t      issue_tag;
	logic               base_pending;
	logic [31:0]        base_value;
	logic               data_pending;
	logic [31:0]        data_value;
	logic               cdb_valid;
	lsq_pkg::tag_t      cdb_tag;
	logic [31:0]        cdb_data;
	logic               mem_resp = 1'b0;
	logic [31:0]        mem_rdata = '0;
	logic               lsq_stall;
	logic               mem_read;
	logic               mem_write;
	logic [31:0]        mem_address;
	logic [3:0]         mem_byte_enable;
	logic [31:0]        mem_wdata;
	logic               result_valid;
	lsq_pkg::tag_t      result_tag;
	logic [31:0]        result_data;

	row_t        rows[$];
	string       names[$];
	int          access_order[$];
	int          result_order[$];
	logic [31:0] tag_val [2**lsq_pkg::tag_width];
	logic [31:0] model_mem [64];
	logic [31:0] ref_mem [64];
	logic [31:0] rng = seed;
	logic        armed;
	int          delay;

	load_store_unit dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// every word differs, upper bytes mix signs
	function automatic logic [31:0] pattern(input int i);
		return (32'(i) * 32'h9e3779b1) ^ 32'hc3a50f81;
	endfunction

	function automatic logic [31:0] encode(input int r);
		if (rows[r].is_load)
			return {rows[r].imm, 5'd1, rows[r].f3, 5'd2, rv32i_pkg::op_load};
		return {rows[r].imm[11:5], 5'd3, 5'd1, rows[r].f3, rows[r].imm[4:0],
				rv32i_pkg::op_store};
	endfunction

	function automatic logic [31:0] eff_addr(input int r);
		logic [31:0] b;
		b = rows[r].base_pend ? tag_val[rows[r].base[lsq_pkg::tag_width-1:0]] : rows[r].base;
		return b + {{20{rows[r].imm[11]}}, rows[r].imm};
	endfunction

	function automatic logic [31:0] store_data(input int r);
		if (rows[r].data_pend)
			return tag_val[rows[r].data[lsq_pkg::tag_width-1:0]];
		return rows[r].data;
	endfunction

	function automatic logic [3:0] lanes(input logic [2:0] f3, input logic [1:0] off);
		if (f3 == rv32i_pkg::f3_w)
			return 4'b1111;
		if (f3 == rv32i_pkg::f3_h)
			return 4'b0011 << off;
		return 4'b0001 << off;
	endfunction

	function automatic logic [31:0] spread(input logic [2:0] f3, input logic [31:0] d);
		if (f3 == rv32i_pkg::f3_b)
			return {4{d[7:0]}};
		if (f3 == rv32i_pkg::f3_h)
			return {2{d[15:0]}};
		return d;
	endfunction

	function automatic logic [31:0] load_value(input logic [2:0] f3, input logic [31:0] w,
			input logic [1:0] off);
		logic [31:0] s;
		s = w >> (off * 8);
		case (f3)
			rv32i_pkg::f3_b:  return {{24{s[7]}}, s[7:0]};
			rv32i_pkg::f3_bu: return {24'b0, s[7:0]};
			rv32i_pkg::f3_h:  return {{16{s[15]}}, s[15:0]};
			rv32i_pkg::f3_hu: return {16'b0, s[15:0]};
			default:          return s;
		endcase
	endfunction

	function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] d,
			input logic [3:0] be);
		logic [31:0] m;
		m = old;
		for (int k = 0; k < 4; k++)
			if (be[k])
				m[k*8 +: 8] = d[k*8 +: 8];
		return m;
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
			stop_run($sformatf("CHECK FAILED %s expected %08h actual %08h", name, exp, act));
	endtask

	task automatic check_tag(input string name, input lsq_pkg::tag_t exp,
			input lsq_pkg::tag_t act);
		if (act !== exp)
			stop_run($sformatf("CHECK FAILED %s expected %0h actual %0h", name, exp, act));
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_run($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
	endtask

	task automatic add_row(input string name, input logic is_load, input logic [2:0] f3,
			input logic [11:0] imm, input logic [31:0] base, input logic [31:0] data);
		row_t row;
		row = '0;
		row.is_load = is_load;
		row.f3      = f3;
		row.imm     = imm;
		row.tag     = lsq_pkg::tag_t'(rows.size());
		row.base    = base;
		row.data    = data;
		rows.push_back(row);
		names.push_back(name);
	endtask

	task automatic bcast_after(input logic [3:0] cycles, input lsq_pkg::tag_t tag,
			input logic [31:0] value);
		rows[rows.size()-1].bcast       = 1'b1;
		rows[rows.size()-1].bcast_wait  = cycles;
		rows[rows.size()-1].bcast_tag   = tag;
		rows[rows.size()-1].bcast_value = value;
	endtask

	task automatic build_table();
		add_row("lb_off0", 1'b1, rv32i_pkg::f3_b, 12'd0, 32'h40, 32'h0);
		add_row("lb_off2", 1'b1, rv32i_pkg::f3_b, 12'd2, 32'h40, 32'h0);
		add_row("lbu_off1", 1'b1, rv32i_pkg::f3_bu, 12'd1, 32'h40, 32'h0);
		add_row("lbu_off3", 1'b1, rv32i_pkg::f3_bu, 12'd3, 32'h44, 32'h0);
		add_row("lh_off0", 1'b1, rv32i_pkg::f3_h, 12'd0, 32'h44, 32'h0);
		add_row("lh_off2", 1'b1, rv32i_pkg::f3_h, 12'd6, 32'h40, 32'h0);
		add_row("lhu_off0", 1'b1, rv32i_pkg::f3_hu, 12'd0, 32'h48, 32'h0);
		add_row("lhu_off2", 1'b1, rv32i_pkg::f3_hu, 12'd2, 32'h48, 32'h0);
		add_row("lw_pos", 1'b1, rv32i_pkg::f3_w, 12'd12, 32'h40, 32'h0);
		add_row("lw_neg", 1'b1, rv32i_pkg::f3_w, 12'hffc, 32'h50, 32'h0);
		add_row("sb_off1", 1'b0, rv32i_pkg::f3_b, 12'd1, 32'h80, 32'h000000c3);
		add_row("sb_off3", 1'b0, rv32i_pkg::f3_b, 12'd3, 32'h80, 32'h12345681);
		add_row("sh_off2", 1'b0, rv32i_pkg::f3_h, 12'd2, 32'h84, 32'hdead8a5f);
		add_row("sh_off0", 1'b0, rv32i_pkg::f3_h, 12'd0, 32'h84, 32'h0000f00d);
		add_row("sw_word", 1'b0, rv32i_pkg::f3_w, 12'd8, 32'h80, 32'hcafe0123);
		add_row("rd_sb", 1'b1, rv32i_pkg::f3_w, 12'd0, 32'h80, 32'h0);
		add_row("rd_sb_sext", 1'b1, rv32i_pkg::f3_b, 12'd3, 32'h80, 32'h0);
		add_row("rd_sh", 1'b1, rv32i_pkg::f3_h, 12'd2, 32'h84, 32'h0);
		add_row("rd_sw", 1'b1, rv32i_pkg::f3_w, 12'd8, 32'h80, 32'h0);
		// data and base wait on tags 9 and 10
		add_row("st_wait_data", 1'b0, rv32i_pkg::f3_w, 12'd0, 32'h90, 32'd9);
		rows[rows.size()-1].data_pend = 1'b1;
		add_row("ld_wait_base", 1'b1, rv32i_pkg::f3_w, 12'd4, 32'd10, 32'h0);
		rows[rows.size()-1].base_pend = 1'b1;
		add_row("ld_behind", 1'b1, rv32i_pkg::f3_bu, 12'd1, 32'h40, 32'h0);
		bcast_after(4'd2, lsq_pkg::tag_t'(9), 32'h5a5aa5a5);
		add_row("ld_behind2", 1'b1, rv32i_pkg::f3_h, 12'd0, 32'h48, 32'h0);
		bcast_after(4'd1, lsq_pkg::tag_t'(10), 32'h8c);
		add_row("rd_wait_data", 1'b1, rv32i_pkg::f3_w, 12'd0, 32'h90, 32'h0);
		// blocked head plus seven more fills the queue
		add_row("blk_head", 1'b1, rv32i_pkg::f3_w, 12'd0, 32'd11, 32'h0);
		rows[rows.size()-1].base_pend = 1'b1;
		rows[rows.size()-1].drain     = 1'b1;
		for (int k = 1; k < 8; k++)
			add_row($sformatf("blk_%0d", k), 1'b1, rv32i_pkg::f3_bu, 12'(k), 32'h40, 32'h0);
		rows[rows.size()-1].stall = 1'b1;
		bcast_after(4'd3, lsq_pkg::tag_t'(11), 32'h40);
	endtask

	task automatic issue_row(input int r);
		@(posedge clk);
		issue_valid  <= 1'b1;
		issue_instr  <= encode(r);
		issue_tag    <= rows[r].tag;
		base_pending <= rows[r].base_pend;
		base_value   <= rows[r].base;
		data_pending <= rows[r].data_pend;
		data_value   <= rows[r].data;
		access_order.push_back(r);
		result_order.push_back(r);
		@(posedge clk);
		issue_valid <= 1'b0;
	endtask

	task automatic broadcast(input int r);
		repeat (rows[r].bcast_wait) @(posedge clk);
		@(posedge clk);
		tag_val[rows[r].bcast_tag] = rows[r].bcast_value;
		cdb_valid <= 1'b1;
		cdb_tag   <= rows[r].bcast_tag;
		cdb_data  <= rows[r].bcast_value;
		@(posedge clk);
		cdb_valid <= 1'b0;
	endtask

	task automatic wait_not_stalled();
		int n = 0;
		@(negedge clk);
		while (lsq_stall) begin
			if (n == timeout_cycles)
				stop_run("timed out waiting for lsq_stall to fall");
			n++;
			@(negedge clk);
		end
	endtask

	task automatic wait_drained();
		int n = 0;
		@(negedge clk);
		while (result_order.size() != 0) begin
			if (n == timeout_cycles)
				stop_run("timed out waiting for all outstanding results");
			n++;
			@(negedge clk);
		end
	endtask

	task automatic check_access();
		int          r;
		logic [31:0] addr;
		if (access_order.size() == 0)
			stop_run("memory strobe raised with no instruction outstanding");
		r = access_order.pop_front();
		addr = eff_addr(r);
		check_level({names[r], " mem_read"}, rows[r].is_load, mem_read);
		check_level({names[r], " mem_write"}, !rows[r].is_load, mem_write);
		check_word({names[r], " mem_address"}, {addr[31:2], 2'b00}, mem_address);
		if (!rows[r].is_load) begin
			check_word({names[r], " mem_byte_enable"}, {28'b0, lanes(rows[r].f3, addr[1:0])},
					{28'b0, mem_byte_enable});
			check_word({names[r], " mem_wdata"}, spread(rows[r].f3, store_data(r)), mem_wdata);
		end
	endtask

	// memory answers 1 to 3 cycles after it sees a strobe
	always @(posedge clk) begin
		if (rst) begin
			mem_resp <= 1'b0;
			armed    <= 1'b0;
		end else if (mem_resp) begin
			mem_resp <= 1'b0;
			armed    <= 1'b0;
		end else if ((mem_read || mem_write) && !armed) begin
			check_access();
			rng = xorshift(rng);
			delay <= 1 + int'(rng % 32'd3);
			armed <= 1'b1;
		end else if (armed && delay > 1) begin
			delay <= delay - 1;
		end else if (armed) begin
			mem_resp  <= 1'b1;
			mem_rdata <= model_mem[mem_address[7:2]];
			if (mem_write)
				model_mem[mem_address[7:2]] = merge(model_mem[mem_address[7:2]], mem_wdata,
						mem_byte_enable);
		end
	end

	// results must come back in issue order
	initial begin
		int          r;
		logic [31:0] addr;
		logic [31:0] exp;
		forever begin
			@(negedge clk);
			if (!rst && result_valid) begin
				if (result_order.size() == 0)
					stop_run("result broadcast with no instruction outstanding");
				r = result_order.pop_front();
				addr = eff_addr(r);
				if (rows[r].is_load) begin
					exp = load_value(rows[r].f3, ref_mem[addr[7:2]], addr[1:0]);
				end else begin
					exp = store_data(r);
					ref_mem[addr[7:2]] = merge(ref_mem[addr[7:2]], spread(rows[r].f3, exp),
							lanes(rows[r].f3, addr[1:0]));
				end
				check_tag({names[r], " result_tag"}, rows[r].tag, result_tag);
				check_word({names[r], " result_data"}, exp, result_data);
			end
		end
	end

	initial begin
		rst          <= 1'b1;
		issue_valid  <= 1'b0;
		issue_instr  <= '0;
		issue_tag    <= '0;
		base_pending <= 1'b0;
		base_value   <= '0;
		data_pending <= 1'b0;
		data_value   <= '0;
		cdb_valid    <= 1'b0;
		cdb_tag      <= '0;
		cdb_data     <= '0;
		build_table();
		for (int i = 0; i < 64; i++) begin
			model_mem[i] = pattern(i);
			ref_mem[i]   = pattern(i);
		end
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_level("reset mem_read", 1'b0, mem_read);
		check_level("reset mem_write", 1'b0, mem_write);
		check_level("reset result_valid", 1'b0, result_valid);
		check_level("reset lsq_stall", 1'b0, lsq_stall);
		repeat (10) begin
			@(negedge clk);
			check_level("idle result_valid", 1'b0, result_valid);
		end
		for (int r = 0; r < rows.size(); r++) begin
			if (rows[r].drain)
				wait_drained();
			wait_not_stalled();
			issue_row(r);
			if (rows[r].stall) begin
				@(negedge clk);
				check_level({names[r], " lsq_stall"}, 1'b1, lsq_stall);
			end
			if (rows[r].bcast)
				broadcast(r);
		end
		wait_drained();
		@(negedge clk);
		check_level("final lsq_stall", 1'b0, lsq_stall);
		check_level("final mem_read", 1'b0, mem_read);
		check_level("final mem_write", 1'b0, mem_write);
		$display("** PASS **");
		$finish;
	end

endmodule

/* files.f */
source/rv32i_pkg.sv
source/lsq_pkg.sv
source/lsq_decode.sv
source/lsq_queue.sv
source/lsq_mem_access.sv
source/lsq_result.sv
source/load_store_unit.sv
tests/load_store_unit_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := load_store_unit_tb
FILELIST  := files.f
BUILD     := obj_dir

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BUILD)/V$(TOP)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)
